// ==== hw/prbs_boot_pkg.sv ====
package prbs_boot_pkg;

    ////////////////////////////////////////
    // Lane geometry
    ////////////////////////////////////////

    // Number of fiber lanes on the tester
    localparam int NUM_LANES = 8;

    // One bit per lane, lane 7 on the left
    typedef logic [NUM_LANES-1:0] lane_vec_t;

    // Front panel only has room for four lanes
    // LED bit k shows lane k + SHOWN_LANE_BASE
    localparam int SHOWN_LANE_BASE = 4;

    ////////////////////////////////////////
    // Boot interval counter
    ////////////////////////////////////////

    localparam int CNT_W = 6;

    // Last count of each reset-release settle interval
    localparam logic [CNT_W-1:0] SETTLE_COUNT      = CNT_W'(3);
    // Last count of the error-inject window
    localparam logic [CNT_W-1:0] INJECT_HOLD_COUNT = CNT_W'(31);

    ////////////////////////////////////////
    // Boot states
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        ST_RESET        = 3'd0,  // everything held in reset
        ST_TX_RELEASE   = 3'd1,  // tx resets released, settling
        ST_TX_WAIT      = 3'd2,  // waiting for tx reset-done flags
        ST_RX_RELEASE   = 3'd3,  // rx resets released, settling
        ST_RX_WAIT      = 3'd4,  // waiting for rx reset-done flags
        ST_INJECT       = 3'd5,  // error-inject window
        ST_INJECT_CLEAR = 3'd6,  // one-cycle counter clear
        ST_CHECK        = 3'd7   // steady PRBS checking
    } boot_state_t;

    // Status codes for the upper LED nibble
    localparam logic [3:0] LED_RESET        = 4'b0001;
    localparam logic [3:0] LED_TX_RELEASE   = 4'b0010;
    localparam logic [3:0] LED_TX_WAIT      = 4'b0011;
    localparam logic [3:0] LED_RX_RELEASE   = 4'b0100;
    localparam logic [3:0] LED_RX_WAIT      = 4'b0101;
    localparam logic [3:0] LED_INJECT       = 4'b0110;
    localparam logic [3:0] LED_INJECT_CLEAR = 4'b0111;
    localparam logic [3:0] LED_CHECK        = 4'b1010;

endpackage

// ==== hw/boot_sequencer.sv ====
`timescale 1ns/1ps

module boot_sequencer import prbs_boot_pkg::*; (
    input  logic       slow_clk40,
    input  logic       PRBS_reset,
    // Per-lane reset-done levels from the transceivers
    input  lane_vec_t  tx_reset_done_i,
    input  lane_vec_t  rx_reset_done_i,
    // Lane resets, all lanes move together
    output lane_vec_t  full_tx_reset_o,
    output lane_vec_t  full_rx_reset_o,
    // PRBS counter clear and forced-error control
    output logic       prbs_cnt_reset_o,
    output logic       prbs_error_inject_o,
    // Boot status code for the front panel
    output logic [3:0] led_status_o
);

    boot_state_t      state_q;
    boot_state_t      state_d;
    logic [CNT_W-1:0] cnt_q;
    logic             cnt_clear;
    logic             settle_done;
    logic             hold_done;
    logic             tx_all_done;
    logic             rx_all_done;

    ////////////////////////////////////////
    // Interval counter
    ////////////////////////////////////////

    // Zeroed in the states that come just before a timed state,
    // so every timed state starts counting at zero
    assign cnt_clear = (state_q == ST_RESET)   ||
                       (state_q == ST_TX_WAIT) ||
                       (state_q == ST_RX_WAIT);

    always_ff @(posedge slow_clk40) begin
        if (PRBS_reset) begin
            cnt_q <= '0;
        end else if (cnt_clear) begin
            cnt_q <= '0;
        end else if (cnt_q != '1) begin
            // Saturate so a long stay in ST_CHECK cannot wrap
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Release states last SETTLE_COUNT+1 cycles
    assign settle_done = (cnt_q == SETTLE_COUNT);
    // Inject window lasts INJECT_HOLD_COUNT+1 cycles
    assign hold_done   = (cnt_q == INJECT_HOLD_COUNT);

    // All lanes must report done before moving on
    assign tx_all_done = &tx_reset_done_i;
    assign rx_all_done = &rx_reset_done_i;

    ////////////////////////////////////////
    // State register and next state
    ////////////////////////////////////////

    always_ff @(posedge slow_clk40) begin
        if (PRBS_reset) begin
            state_q <= ST_RESET;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        // Stay put unless a condition below fires
        state_d = state_q;
        case (state_q)
            ST_RESET: begin
                // Single cycle with everything held
                state_d = ST_TX_RELEASE;
            end
            ST_TX_RELEASE: begin
                if (settle_done) begin
                    state_d = ST_TX_WAIT;
                end
            end
            ST_TX_WAIT: begin
                if (tx_all_done) begin
                    state_d = ST_RX_RELEASE;
                end
            end
            ST_RX_RELEASE: begin
                if (settle_done) begin
                    state_d = ST_RX_WAIT;
                end
            end
            ST_RX_WAIT: begin
                if (rx_all_done) begin
                    state_d = ST_INJECT;
                end
            end
            ST_INJECT: begin
                if (hold_done) begin
                    state_d = ST_INJECT_CLEAR;
                end
            end
            ST_INJECT_CLEAR: begin
                // Counters wiped once after the forced errors
                state_d = ST_CHECK;
            end
            ST_CHECK: begin
                // Terminal until the next reset
                state_d = ST_CHECK;
            end
            default: begin
                state_d = ST_RESET;
            end
        endcase
    end

    ////////////////////////////////////////
    // Moore output decode
    ////////////////////////////////////////

    // Tx lanes only held in the reset state itself
    assign full_tx_reset_o = (state_q == ST_RESET) ? '1 : '0;

    // Rx lanes stay held until tx side is up
    assign full_rx_reset_o = ((state_q == ST_RESET)      ||
                              (state_q == ST_TX_RELEASE) ||
                              (state_q == ST_TX_WAIT)) ? '1 : '0;

    // PRBS counters held through bring-up, pulsed again after inject
    assign prbs_cnt_reset_o = (state_q == ST_RESET)      ||
                              (state_q == ST_TX_RELEASE) ||
                              (state_q == ST_TX_WAIT)    ||
                              (state_q == ST_RX_RELEASE) ||
                              (state_q == ST_INJECT_CLEAR);

    // Inject starts while rx is still coming up
    assign prbs_error_inject_o = (state_q == ST_RX_WAIT) ||
                                 (state_q == ST_INJECT);

    always_comb begin
        case (state_q)
            ST_RESET:        led_status_o = LED_RESET;
            ST_TX_RELEASE:   led_status_o = LED_TX_RELEASE;
            ST_TX_WAIT:      led_status_o = LED_TX_WAIT;
            ST_RX_RELEASE:   led_status_o = LED_RX_RELEASE;
            ST_RX_WAIT:      led_status_o = LED_RX_WAIT;
            ST_INJECT:       led_status_o = LED_INJECT;
            ST_INJECT_CLEAR: led_status_o = LED_INJECT_CLEAR;
            ST_CHECK:        led_status_o = LED_CHECK;
            default:         led_status_o = LED_RESET;
        endcase
    end

endmodule

// ==== hw/lane_error_monitor.sv ====
`timescale 1ns/1ps

module lane_error_monitor import prbs_boot_pkg::*; (
    input  logic       slow_clk40,
    input  logic       PRBS_reset,
    // Clear from the sequencer, same as the PRBS counter reset
    input  logic       prbs_cnt_reset_i,
    // Per-lane error strobes from the PRBS checkers
    input  lane_vec_t  prbs_error_i,
    // Sticky error flags, one per lane
    output lane_vec_t  lane_error_o,
    // Error flags for the shown lanes, with blink
    output logic [3:0] led_error_o
);

    lane_vec_t  lane_error_q;
    logic       blink_q;
    logic [3:0] shown_errors;

    ////////////////////////////////////////
    // Sticky error register
    ////////////////////////////////////////

    // A single strobe on any lane latches until the next clear
    always_ff @(posedge slow_clk40) begin
        if (PRBS_reset || prbs_cnt_reset_i) begin
            lane_error_q <= '0;
        end else begin
            lane_error_q <= lane_error_q | prbs_error_i;
        end
    end

    assign lane_error_o = lane_error_q;

    ////////////////////////////////////////
    // Blink phase
    ////////////////////////////////////////

    // Free-running toggle, half the clock rate
    always_ff @(posedge slow_clk40) begin
        if (PRBS_reset) begin
            blink_q <= 1'b0;
        end else begin
            blink_q <= ~blink_q;
        end
    end

    ////////////////////////////////////////
    // LED error nibble
    ////////////////////////////////////////

    // Only the upper four lanes fit on the panel
    assign shown_errors = lane_error_q[SHOWN_LANE_BASE +: 4];

    // Blank while the counters are held, since flags mean nothing then
    // Otherwise a lit bit is steady on error, flashing on a clean lane
    assign led_error_o = prbs_cnt_reset_i ? 4'b0000
                                          : (shown_errors | {4{blink_q}});

endmodule

// ==== hw/prbs_link_top.sv ====
`timescale 1ns/1ps

module prbs_link_top import prbs_boot_pkg::*; (
    input  logic       slow_clk40,
    input  logic       PRBS_reset,
    // Status levels and strobes from the transceiver lanes
    input  lane_vec_t  tx_reset_done_i,
    input  lane_vec_t  rx_reset_done_i,
    input  lane_vec_t  prbs_error_i,
    // Lane control back to the transceivers
    output lane_vec_t  full_tx_reset_o,
    output lane_vec_t  full_rx_reset_o,
    output logic       prbs_cnt_reset_o,
    output logic       prbs_error_inject_o,
    // Sticky per-lane error flags
    output lane_vec_t  lane_error_o,
    // Front panel, status code on top, error flags below
    output logic [7:0] led_fp_o
);

    logic [3:0] led_status;
    logic [3:0] led_error;

    ////////////////////////////////////////
    // Boot sequencer
    ////////////////////////////////////////

    boot_sequencer u_boot_sequencer (
        .slow_clk40          (slow_clk40),
        .PRBS_reset          (PRBS_reset),
        .tx_reset_done_i     (tx_reset_done_i),
        .rx_reset_done_i     (rx_reset_done_i),
        .full_tx_reset_o     (full_tx_reset_o),
        .full_rx_reset_o     (full_rx_reset_o),
        .prbs_cnt_reset_o    (prbs_cnt_reset_o),
        .prbs_error_inject_o (prbs_error_inject_o),
        .led_status_o        (led_status)
    );

    ////////////////////////////////////////
    // Error monitor
    ////////////////////////////////////////

    // Counter reset doubles as the sticky register clear
    lane_error_monitor u_lane_error_monitor (
        .slow_clk40       (slow_clk40),
        .PRBS_reset       (PRBS_reset),
        .prbs_cnt_reset_i (prbs_cnt_reset_o),
        .prbs_error_i     (prbs_error_i),
        .lane_error_o     (lane_error_o),
        .led_error_o      (led_error)
    );

    // Upper nibble status, lower nibble lanes 7..4
    assign led_fp_o = {led_status, led_error};

endmodule

// ==== verif/prbs_link_checker.sv ====
`timescale 1ns/1ps

module prbs_link_checker import prbs_boot_pkg::*; (
    input logic       slow_clk40,
    input logic       PRBS_reset,
    input lane_vec_t  tx_done_i,
    input lane_vec_t  rx_done_i,
    input lane_vec_t  tx_reset_i,
    input lane_vec_t  rx_reset_i,
    input logic       cnt_reset_i,
    input logic       inject_i,
    input logic [7:0] led_fp_i
);

    logic [3:0]  status;
    logic [3:0]  status_q;
    logic [3:0]  exp_wait_q;
    logic [3:0]  row;
    int unsigned dwell_q;
    // Failed assertions so far, polled by the testbench top
    int unsigned fail_count = 0;

    ////////////////////////////////////////
    // Expected boot behavior
    ////////////////////////////////////////

    // Boot order of the status codes, nothing follows check
    function automatic logic [3:0] next_code(logic [3:0] code);
        case (code)
            LED_RESET:        return LED_TX_RELEASE;
            LED_TX_RELEASE:   return LED_TX_WAIT;
            LED_TX_WAIT:      return LED_RX_RELEASE;
            LED_RX_RELEASE:   return LED_RX_WAIT;
            LED_RX_WAIT:      return LED_INJECT;
            LED_INJECT:       return LED_INJECT_CLEAR;
            LED_INJECT_CLEAR: return LED_CHECK;
            default:          return 4'b0000;
        endcase
    endfunction

    // Fixed length of a timed status, 0 when the length varies
    function automatic int unsigned fixed_dwell(logic [3:0] code);
        case (code)
            LED_RESET:        return 1;
            LED_TX_RELEASE:   return int'(SETTLE_COUNT) + 1;
            LED_RX_RELEASE:   return int'(SETTLE_COUNT) + 1;
            LED_INJECT:       return int'(INJECT_HOLD_COUNT) + 1;
            LED_INJECT_CLEAR: return 1;
            default:          return 0;
        endcase
    endfunction

    // Output table row {tx reset, rx reset, counter reset, inject}
    function automatic logic [3:0] table_row(logic [3:0] code);
        case (code)
            LED_RESET:        return 4'b1110;
            LED_TX_RELEASE:   return 4'b0110;
            LED_TX_WAIT:      return 4'b0110;
            LED_RX_RELEASE:   return 4'b0010;
            LED_RX_WAIT:      return 4'b0001;
            LED_INJECT:       return 4'b0001;
            LED_INJECT_CLEAR: return 4'b0010;
            default:          return 4'b0000;
        endcase
    endfunction

    assign status = led_fp_i[7:4];
    assign row    = table_row(status);

    // Previous status, its run length, and where a wait state must go
    always_ff @(posedge slow_clk40) begin
        if (PRBS_reset) begin
            status_q <= LED_RESET;
            dwell_q  <= 0;
        end else begin
            status_q <= status;
            dwell_q  <= (status != status_q) ? 1 : dwell_q + 1;
            // Wait states leave only once every lane reports done
            if (status == LED_TX_WAIT) begin
                exp_wait_q <= (&tx_done_i) ? LED_RX_RELEASE : LED_TX_WAIT;
            end else begin
                exp_wait_q <= (&rx_done_i) ? LED_INJECT : LED_RX_WAIT;
            end
        end
    end

    ////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////

    // Reset values in the cycle after PRBS_reset is seen
    reset_values: assert property (@(posedge slow_clk40)
        PRBS_reset |=> (led_fp_i == 8'h10) && (tx_reset_i == '1) && (rx_reset_i == '1)
                       && cnt_reset_i && !inject_i)
        else begin
            fail_count++;
            $error("CHECK FAILED led_fp_o got %h expected 10, tx %h rx %h cnt %h inj %h",
                   $sampled(led_fp_i), $sampled(tx_reset_i), $sampled(rx_reset_i),
                   $sampled(cnt_reset_i), $sampled(inject_i));
        end

    status_order: assert property (@(posedge slow_clk40) disable iff (PRBS_reset)
        (status != status_q) |-> (status == next_code(status_q)))
        else begin
            fail_count++;
            $error("CHECK FAILED led_fp_o status got %h expected %h",
                   $sampled(status), next_code($sampled(status_q)));
        end

    status_dwell: assert property (@(posedge slow_clk40) disable iff (PRBS_reset)
        (status != status_q && fixed_dwell(status_q) != 0)
            |-> (dwell_q == fixed_dwell(status_q)))
        else begin
            fail_count++;
            $error("CHECK FAILED dwell of status %h got %h expected %h",
                   $sampled(status_q), $sampled(dwell_q), fixed_dwell($sampled(status_q)));
        end

    // Leave a wait state exactly one cycle after the flags are all ones
    wait_exit: assert property (@(posedge slow_clk40) disable iff (PRBS_reset)
        (status_q == LED_TX_WAIT || status_q == LED_RX_WAIT) |-> (status == exp_wait_q))
        else begin
            fail_count++;
            $error("CHECK FAILED led_fp_o status after wait got %h expected %h",
                   $sampled(status), $sampled(exp_wait_q));
        end

    tx_reset_table: assert property (@(posedge slow_clk40) disable iff (PRBS_reset)
        tx_reset_i == {NUM_LANES{row[3]}})
        else begin
            fail_count++;
            $error("CHECK FAILED full_tx_reset_o got %h expected %h",
                   $sampled(tx_reset_i), {NUM_LANES{$sampled(row[3])}});
        end

    rx_reset_table: assert property (@(posedge slow_clk40) disable iff (PRBS_reset)
        rx_reset_i == {NUM_LANES{row[2]}})
        else begin
            fail_count++;
            $error("CHECK FAILED full_rx_reset_o got %h expected %h",
                   $sampled(rx_reset_i), {NUM_LANES{$sampled(row[2])}});
        end

    cnt_reset_table: assert property (@(posedge slow_clk40) disable iff (PRBS_reset)
        cnt_reset_i == row[1])
        else begin
            fail_count++;
            $error("CHECK FAILED prbs_cnt_reset_o got %h expected %h",
                   $sampled(cnt_reset_i), $sampled(row[1]));
        end

    // High exactly in the rx wait and inject states
    inject_table: assert property (@(posedge slow_clk40) disable iff (PRBS_reset)
        inject_i == row[0])
        else begin
            fail_count++;
            $error("CHECK FAILED prbs_error_inject_o got %h expected %h",
                   $sampled(inject_i), $sampled(row[0]));
        end

endmodule

// Attach to the DUT top
bind prbs_link_top prbs_link_checker u_prbs_link_checker (
    .slow_clk40  (slow_clk40),
    .PRBS_reset  (PRBS_reset),
    .tx_done_i   (tx_reset_done_i),
    .rx_done_i   (rx_reset_done_i),
    .tx_reset_i  (full_tx_reset_o),
    .rx_reset_i  (full_rx_reset_o),
    .cnt_reset_i (prbs_cnt_reset_o),
    .inject_i    (prbs_error_inject_o),
    .led_fp_i    (led_fp_o)
);

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    // Restart request, seen on the next falling edge
    input  logic reset_req_i,
    output logic slow_clk40,
    output logic PRBS_reset
);

    // Falling edges left before reset drops
    int unsigned reset_left;

    initial begin
        slow_clk40 = 1'b0;
        PRBS_reset = 1'b1;
        reset_left = RESET_CYCLES;
    end

    // First rising edge at half a period
    always #(PERIOD_NS / 2) slow_clk40 = ~slow_clk40;

    // Reset changes on falling edges only, held over RESET_CYCLES rising edges
    always @(negedge slow_clk40) begin
        if (reset_req_i) begin
            PRBS_reset <= 1'b1;
            reset_left <= RESET_CYCLES;
        end else if (reset_left != 0) begin
            reset_left <= reset_left - 1;
            PRBS_reset <= (reset_left > 1);
        end
    end

endmodule

// ==== verif/tb_prbs_link.sv ====
`timescale 1ns/1ps

module tb_prbs_link import prbs_boot_pkg::*; ();

    // Two boots of about 90 cycles, each followed by 200 check cycles,
    // fit well under this limit
    localparam int MAX_CYCLES   = 1000;
    localparam int CHECK_CYCLES = 200;

    logic        slow_clk40;
    logic        PRBS_reset;
    logic        reset_req;
    lane_vec_t   tx_reset_done;
    lane_vec_t   rx_reset_done;
    lane_vec_t   prbs_error;
    lane_vec_t   full_tx_reset;
    lane_vec_t   full_rx_reset;
    lane_vec_t   lane_error;
    logic        prbs_cnt_reset;
    logic        prbs_error_inject;
    logic [7:0]  led_fp;

    // Model of the sticky register and blink phase
    lane_vec_t   model_err;
    logic        model_blink;
    logic        cnt_reset_prev;
    logic [3:0]  exp_led_err;

    logic [31:0] lfsr_q      = 32'h272d8645;
    int unsigned cycle_count = 0;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) u_clock_gen (
        .reset_req_i (reset_req),
        .slow_clk40  (slow_clk40),
        .PRBS_reset  (PRBS_reset)
    );

    prbs_link_top dut_i (
        .slow_clk40          (slow_clk40),
        .PRBS_reset          (PRBS_reset),
        .tx_reset_done_i     (tx_reset_done),
        .rx_reset_done_i     (rx_reset_done),
        .prbs_error_i        (prbs_error),
        .full_tx_reset_o     (full_tx_reset),
        .full_rx_reset_o     (full_rx_reset),
        .prbs_cnt_reset_o    (prbs_cnt_reset),
        .prbs_error_inject_o (prbs_error_inject),
        .lane_error_o        (lane_error),
        .led_fp_o            (led_fp)
    );

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic fail_run(string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first failure");
    endtask

    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit drawn
    function automatic int unsigned rand_bits(int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Next falling edge, with sparse strobes once errors can be counted
    task automatic next_cycle();
        lane_vec_t strobe;
        @(negedge slow_clk40);
        strobe = '0;
        if (led_fp[7:4] == LED_INJECT || led_fp[7:4] == LED_CHECK) begin
            if (rand_bits(3) == 0) begin
                strobe[3'(rand_bits(3))] = 1'b1;
            end
        end
        prbs_error <= strobe;
    endtask

    // Unknown status at start-up counts as not there yet
    task automatic wait_status(logic [3:0] code);
        while (led_fp[7:4] !== code) begin
            next_cycle();
        end
    endtask

    task automatic boot_pass(bit mid_reset);
        if (mid_reset) begin
            next_cycle();
            reset_req     <= 1'b1;
            tx_reset_done <= '0;
            rx_reset_done <= '0;
            next_cycle();
            reset_req     <= 1'b0;
        end
        wait_status(LED_TX_WAIT);
        // Done flags come up after a random 0-15 cycles
        repeat (rand_bits(4)) begin
            next_cycle();
        end
        tx_reset_done <= '1;
        wait_status(LED_RX_WAIT);
        repeat (rand_bits(4)) begin
            next_cycle();
        end
        rx_reset_done <= '1;
        wait_status(LED_CHECK);
        repeat (CHECK_CYCLES) begin
            next_cycle();
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        reset_req     = 1'b0;
        tx_reset_done = '0;
        rx_reset_done = '0;
        prbs_error    = '0;
        boot_pass(1'b0);
        // Second boot from a reset in the middle of checking
        boot_pass(1'b1);
        // Rising edge after the last model check has run
        @(posedge slow_clk40);
        if (dut_i.u_prbs_link_checker.fail_count != 0) begin
            fail_run("an assertion in the bound checker failed");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

    // Model update and checks, registers as of the rising edge just passed
    always @(negedge slow_clk40) begin
        if (PRBS_reset || cnt_reset_prev) begin
            model_err = '0;
        end else begin
            model_err = model_err | prbs_error;
        end
        model_blink    = PRBS_reset ? 1'b0 : ~model_blink;
        cnt_reset_prev = prbs_cnt_reset;
        // Blank while the counters are held
        exp_led_err = prbs_cnt_reset ? 4'b0000
                                     : (model_err[SHOWN_LANE_BASE +: 4] | {4{model_blink}});
        if (dut_i.u_prbs_link_checker.fail_count != 0) begin
            fail_run("an assertion in the bound checker failed");
        end
        assert (lane_error == model_err)
            else fail_run($sformatf("CHECK FAILED lane_error_o got %h expected %h",
                                    lane_error, model_err));
        assert (led_fp[3:0] == exp_led_err)
            else fail_run($sformatf("CHECK FAILED led_fp_o[3:0] got %h expected %h",
                                    led_fp[3:0], exp_led_err));
    end

    // Hang guard
    always @(posedge slow_clk40) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            fail_run($sformatf("timeout, run still going after %0d cycles", MAX_CYCLES));
        end
    end

endmodule

// ==== verilog.f ====
hw/prbs_boot_pkg.sv
hw/boot_sequencer.sv
hw/lane_error_monitor.sv
hw/prbs_link_top.sv
verif/prbs_link_checker.sv
verif/tb_clock_gen.sv
verif/tb_prbs_link.sv

// ==== Makefile ====
# Verilator flow for the PRBS link tester
VERILATOR ?= verilator
TOP       ?= tb_prbs_link
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  := *** TEST FAILED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -qF '$(FAIL_MSG)' $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
